//--- Bender.yml
package:
  name: fetch_front_end

export_include_dirs:
  - include

sources:
  - files:
      - src/fetch_pkg.sv
      - src/fetch_pc_gen.sv
      - src/fetch_ctrl.sv
      - src/fetch_imem.sv
      - src/fetch_predecode.sv
      - src/fetch_top.sv
  - target: test
    files:
      - verif/fetch_clkgen.sv
      - verif/fetch_checker.sv
      - verif/fetch_tb.sv

//--- include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Byte address width of the fetch path
`define FETCH_ADDR_BITS 16

// Instruction memory depth in 32-bit words
`define FETCH_MEM_WORDS 256

// First address fetched after reset
`define FETCH_RESET_PC 16'h0100

`endif

//--- sim.f
+incdir+include
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_ctrl.sv
src/fetch_imem.sv
src/fetch_predecode.sv
src/fetch_top.sv
verif/fetch_clkgen.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- src/fetch_ctrl.sv
`include "fetch_defines.svh"

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_bp_valid,
    input  logic [`FETCH_ADDR_BITS-1:0] i_bp_pc,
    input  logic                        i_mem_ready,
    input  mem_resp_t                   i_mem_resp,
    output mem_req_t                    o_mem_req,
    output logic                        o_req_accepted,
    input  logic                        i_flush,
    input  logic                        i_progbuf_ena,
    input  logic [`FETCH_ADDR_BITS-1:0] i_progbuf_pc,
    input  logic [31:0]                 i_progbuf_instr,
    output fetch_out_t                  o_raw,
    output logic [`FETCH_ADDR_BITS-1:0] o_fetching_pc
);

    typedef struct packed {
        fetch_state_e                state;
        logic                        req_valid;
        logic [`FETCH_ADDR_BITS-1:0] req_addr;
        logic [`FETCH_ADDR_BITS-1:0] shadow;
        logic                        resp_ready;
        logic                        drop;
        fetch_out_t                  raw;
    } ctrl_regs_t;

    localparam ctrl_regs_t CTRL_RESET = '{
        state:      st_idle,
        req_valid:  1'b0,
        req_addr:   '1,
        shadow:     '1,
        resp_ready: 1'b0,
        drop:       1'b0,
        raw:        '{valid: 1'b0, pc: '1, instr: '0, compressed: 1'b0,
                      load_fault: 1'b0, progbuf: 1'b0}
    };

    ctrl_regs_t r, rin;
    logic       accepted;
    logic       resp_seen;

    assign accepted  = r.req_valid && i_mem_ready;
    // A response only counts when one is due this cycle
    assign resp_seen = i_mem_resp.data_valid && r.resp_ready;

    always_comb begin
        rin = r;
        rin.raw.valid = 1'b0;
        case (r.state)
            st_idle: begin
                if (i_progbuf_ena) begin
                    // Injected instruction bypasses memory
                    rin.raw.valid      = 1'b1;
                    rin.raw.pc         = i_progbuf_pc;
                    rin.raw.instr      = i_progbuf_instr;
                    rin.raw.load_fault = 1'b0;
                    rin.raw.progbuf    = 1'b1;
                end else if (i_bp_valid) begin
                    rin.state     = st_wait_req_accept;
                    rin.req_valid = 1'b1;
                    rin.req_addr  = i_bp_pc;
                end
            end
            st_wait_req_accept: begin
                if (i_mem_ready) begin
                    rin.req_valid = i_bp_valid && !i_progbuf_ena;
                    rin.req_addr  = i_bp_pc;
                    rin.shadow    = r.req_addr;
                    rin.state     = st_wait_resp;
                end else if (i_bp_valid) begin
                    // Address may still move while the request waits
                    rin.req_addr = i_bp_pc;
                end
            end
            st_wait_resp: begin
                if (resp_seen) begin
                    if (!r.drop) begin
                        rin.raw.valid      = 1'b1;
                        rin.raw.pc         = i_mem_resp.addr;
                        rin.raw.instr      = i_mem_resp.data;
                        rin.raw.load_fault = i_mem_resp.load_fault;
                        rin.raw.progbuf    = 1'b0;
                    end
                    if (r.req_valid) begin
                        if (i_mem_ready) begin
                            // Next request overlaps this response
                            rin.req_valid = i_bp_valid && !i_progbuf_ena;
                            rin.req_addr  = i_bp_pc;
                            rin.shadow    = r.req_addr;
                        end else begin
                            rin.state = st_wait_req_accept;
                        end
                    end else if (i_bp_valid && !i_progbuf_ena) begin
                        rin.req_valid = 1'b1;
                        rin.req_addr  = i_bp_pc;
                        rin.state     = st_wait_req_accept;
                    end else begin
                        rin.req_addr = '1;
                        rin.state    = st_idle;
                    end
                end
            end
            default: begin
                rin.state = st_idle;
            end
        endcase

        if (i_flush) begin
            rin.req_valid      = 1'b0;
            rin.raw.valid      = 1'b0;
            rin.raw.pc         = '1;
            rin.raw.instr      = '0;
            rin.raw.load_fault = 1'b0;
            rin.raw.progbuf    = 1'b0;
            // A request taken this cycle still returns data, wait for it
            rin.state = accepted ? st_wait_resp : st_idle;
        end
        rin.drop       = i_flush && accepted;
        rin.resp_ready = accepted;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r <= CTRL_RESET;
        end else begin
            r <= rin;
        end
    end

    assign o_mem_req      = '{valid: r.req_valid, addr: r.req_addr};
    assign o_req_accepted = accepted;
    assign o_raw          = r.raw;
    assign o_fetching_pc  = r.shadow;

endmodule

//--- src/fetch_imem.sv
`include "fetch_defines.svh"

module fetch_imem
    import fetch_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_we,
    input  logic [`FETCH_ADDR_BITS-1:0] i_waddr,
    input  logic [31:0]                 i_wdata,
    input  logic                        i_stall,
    input  mem_req_t                    i_req,
    output logic                        o_ready,
    output mem_resp_t                   o_resp
);

    localparam int WORD_BITS = `FETCH_ADDR_BITS - 2;
    localparam int IDX_BITS  = $clog2(`FETCH_MEM_WORDS);
    localparam logic [WORD_BITS-1:0] DEPTH = WORD_BITS'(`FETCH_MEM_WORDS);

    logic [31:0] mem [0:`FETCH_MEM_WORDS-1];

    logic [WORD_BITS-1:0]        req_word;
    logic [WORD_BITS-1:0]        wr_word;
    logic                        req_in_range;
    logic                        wr_in_range;
    logic                        accept;

    logic                        resp_valid;
    logic [`FETCH_ADDR_BITS-1:0] resp_addr;
    logic [31:0]                 resp_data;
    logic                        resp_fault;

    // Word addresses, byte offset ignored
    assign req_word = i_req.addr[`FETCH_ADDR_BITS-1:2];
    assign wr_word  = i_waddr[`FETCH_ADDR_BITS-1:2];

    assign req_in_range = req_word < DEPTH;
    assign wr_in_range  = wr_word < DEPTH;

    assign o_ready = !i_stall;
    assign accept  = i_req.valid && o_ready;

    // Program load port
    always_ff @(posedge i_clk) begin
        if (i_we && wr_in_range) begin
            mem[wr_word[IDX_BITS-1:0]] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    // Out of range reads fault and return zero
    always_ff @(posedge i_clk) begin
        if (accept) begin
            resp_addr  <= i_req.addr;
            resp_fault <= !req_in_range;
            resp_data  <= req_in_range ? mem[req_word[IDX_BITS-1:0]] : 32'h0;
        end
    end

    assign o_resp = '{
        data_valid: resp_valid,
        addr:       resp_addr,
        data:       resp_data,
        load_fault: resp_fault
    };

endmodule

//--- src/fetch_pc_gen.sv
`include "fetch_defines.svh"

module fetch_pc_gen (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_fetch_en,
    input  logic                        i_flush,
    input  logic [`FETCH_ADDR_BITS-1:0] i_redirect_pc,
    input  logic                        i_req_accepted,
    output logic                        o_bp_valid,
    output logic [`FETCH_ADDR_BITS-1:0] o_bp_pc
);

    // Address of the next request not yet taken by memory
    logic [`FETCH_ADDR_BITS-1:0] next_pc;
    logic [`FETCH_ADDR_BITS-1:0] next_pc_inc;

    assign next_pc_inc = next_pc + `FETCH_ADDR_BITS'(4);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            next_pc <= `FETCH_RESET_PC;
        end else if (i_flush) begin
            next_pc <= i_redirect_pc;
        end else if (i_req_accepted) begin
            next_pc <= next_pc_inc;
        end
    end

    // No proposal while a redirect is loading
    assign o_bp_valid = i_fetch_en && !i_flush;

    // The controller samples bp_pc in the same cycle that memory takes the
    // current request, so look one step ahead on acceptance
    assign o_bp_pc = i_req_accepted ? next_pc_inc : next_pc;

endmodule

//--- src/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // Controller states
    typedef enum logic [1:0] {
        st_idle            = 2'd0,
        st_wait_req_accept = 2'd1,
        st_wait_resp       = 2'd2
    } fetch_state_e;

    typedef struct packed {
        logic                        valid;
        logic [`FETCH_ADDR_BITS-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                        data_valid;
        logic [`FETCH_ADDR_BITS-1:0] addr;
        logic [31:0]                 data;
        logic                        load_fault;
    } mem_resp_t;

    // Base 32-bit instruction layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } full_instr_t;

    // Two 16-bit compressed halves, low half executes first
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } compressed_pair_t;

    typedef union packed {
        full_instr_t      full;
        compressed_pair_t pair;
    } fetch_word_u;

    typedef struct packed {
        logic                        valid;
        logic [`FETCH_ADDR_BITS-1:0] pc;
        fetch_word_u                 instr;
        logic                        compressed;
        logic                        load_fault;
        logic                        progbuf;
    } fetch_out_t;

endpackage

//--- src/fetch_predecode.sv
`include "fetch_defines.svh"

module fetch_predecode
    import fetch_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_nrst,
    input  fetch_out_t i_raw,
    output fetch_out_t o_fetch
);

    localparam fetch_out_t FETCH_RESET = '{
        valid:      1'b0,
        pc:         '1,
        instr:      '0,
        compressed: 1'b0,
        load_fault: 1'b0,
        progbuf:    1'b0
    };

    fetch_word_u word;
    logic        is_compressed;
    fetch_out_t  decoded;

    assign word = i_raw.instr;

    // Low half is a 16-bit instruction unless its two low bits are 11
    assign is_compressed = (word.pair.lo[1:0] != 2'b11);

    always_comb begin
        decoded            = i_raw;
        decoded.compressed = is_compressed;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_fetch <= FETCH_RESET;
        end else begin
            o_fetch <= decoded;
        end
    end

endmodule

//--- src/fetch_top.sv
`include "fetch_defines.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_fetch_en,
    input  logic                        i_flush,
    input  logic [`FETCH_ADDR_BITS-1:0] i_redirect_pc,
    input  logic                        i_stall,
    input  logic                        i_we,
    input  logic [`FETCH_ADDR_BITS-1:0] i_waddr,
    input  logic [31:0]                 i_wdata,
    input  logic                        i_progbuf_ena,
    input  logic [`FETCH_ADDR_BITS-1:0] i_progbuf_pc,
    input  logic [31:0]                 i_progbuf_instr,
    output fetch_out_t                  o_fetch,
    output logic [`FETCH_ADDR_BITS-1:0] o_fetching_pc
);

    logic                        bp_valid;
    logic [`FETCH_ADDR_BITS-1:0] bp_pc;
    logic                        req_accepted;
    logic                        mem_ready;
    mem_req_t                    mem_req;
    mem_resp_t                   mem_resp;
    fetch_out_t                  raw;

    fetch_pc_gen u_pc_gen (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_fetch_en     (i_fetch_en),
        .i_flush        (i_flush),
        .i_redirect_pc  (i_redirect_pc),
        .i_req_accepted (req_accepted),
        .o_bp_valid     (bp_valid),
        .o_bp_pc        (bp_pc)
    );

    fetch_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_bp_valid      (bp_valid),
        .i_bp_pc         (bp_pc),
        .i_mem_ready     (mem_ready),
        .i_mem_resp      (mem_resp),
        .o_mem_req       (mem_req),
        .o_req_accepted  (req_accepted),
        .i_flush         (i_flush),
        .i_progbuf_ena   (i_progbuf_ena),
        .i_progbuf_pc    (i_progbuf_pc),
        .i_progbuf_instr (i_progbuf_instr),
        .o_raw           (raw),
        .o_fetching_pc   (o_fetching_pc)
    );

    fetch_imem u_imem (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_we    (i_we),
        .i_waddr (i_waddr),
        .i_wdata (i_wdata),
        .i_stall (i_stall),
        .i_req   (mem_req),
        .o_ready (mem_ready),
        .o_resp  (mem_resp)
    );

    fetch_predecode u_predecode (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_raw   (raw),
        .o_fetch (o_fetch)
    );

endmodule

//--- verif/fetch_checker.sv
module fetch_checker
    import fetch_pkg::*;
(
    input logic         i_clk,
    input logic         i_nrst,
    input fetch_state_e i_state,
    input mem_req_t     i_req,
    input logic         i_mem_ready,
    input mem_resp_t    i_mem_resp,
    input logic         i_flush,
    input fetch_out_t   i_raw
);

    timeunit 1ns;
    timeprecision 100ps;

    // Count of failed assertions, watched by the testbench
    int fail_count = 0;

    // A request waiting on memory holds until taken
    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_state == st_wait_req_accept && !i_mem_ready && !i_flush)
            |=> (i_state == st_wait_req_accept && i_req.valid))
    else begin
        fail_count++;
        $error("stalled request dropped or controller left wait_req_accept");
    end

    a_idle_no_resp: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_state == st_idle) |-> !i_mem_resp.data_valid)
    else begin
        fail_count++;
        $error("memory data valid seen while controller idle");
    end

    // Data for a request taken during a flush is dropped on arrival
    a_flush_kill: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_flush && i_req.valid && i_mem_ready) |=> ##1 !i_raw.valid)
    else begin
        fail_count++;
        $error("response to a request taken during a flush reached the raw output");
    end

endmodule

//--- verif/fetch_clkgen.sv
module fetch_clkgen (
    output logic o_clk,
    output logic o_nrst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Release lands on a falling edge, away from the rising edge
    initial begin
        o_nrst = 1'b0;
        #(2 * HALF_PERIOD * RESET_CYCLES);
        o_nrst = 1'b1;
    end

endmodule

//--- verif/fetch_tb.sv
`include "fetch_defines.svh"

module fetch_tb
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS    = `FETCH_MEM_WORDS;
    localparam int NUM_PHASES   = 9;
    // Pending request to o_fetch, with margin
    localparam int DRAIN_CYCLES = 6;

    typedef logic [`FETCH_ADDR_BITS-1:0] addr_t;

    typedef struct packed {
        logic       fetch_en;
        logic [1:0] stall_quarters;
        logic       flush;
        addr_t      redirect_pc;
        logic       progbuf;
        logic [7:0] count;
    } phase_t;

    // Stall is a chance in quarters per cycle
    localparam phase_t PHASES [NUM_PHASES] = '{
        '{1'b1, 2'd0, 1'b0, 16'h0000, 1'b0, 8'd12},
        '{1'b1, 2'd3, 1'b0, 16'h0000, 1'b0, 8'd16},
        '{1'b1, 2'd0, 1'b1, 16'h0040, 1'b0, 8'd8},
        '{1'b1, 2'd2, 1'b0, 16'h0000, 1'b0, 8'd8},
        // Crosses the end of memory into faulting words
        '{1'b1, 2'd0, 1'b1, 16'h03f8, 1'b0, 8'd6},
        '{1'b1, 2'd1, 1'b1, 16'h0800, 1'b0, 8'd6},
        '{1'b0, 2'd0, 1'b0, 16'h0000, 1'b1, 8'd1},
        '{1'b1, 2'd1, 1'b1, 16'h0200, 1'b0, 8'd10},
        '{1'b0, 2'd0, 1'b0, 16'h0000, 1'b1, 8'd1}
    };

    logic        clk;
    logic        nrst;
    logic        fetch_en;
    logic        flush;
    logic        stall;
    logic        we;
    logic        progbuf_ena;
    addr_t       redirect_pc;
    addr_t       waddr;
    addr_t       progbuf_pc;
    logic [31:0] wdata;
    logic [31:0] progbuf_instr;
    fetch_out_t  dut_fetch;
    addr_t       fetching_pc;

    // Reference model state
    logic [31:0] model_mem [MEM_WORDS];
    addr_t       exp_pc;
    logic        exp_progbuf;
    logic        shadow_known;
    int          results_seen;
    int          total_expected;
    int          cycles;
    int          cycle_limit;

    fetch_clkgen u_clkgen (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    fetch_top dut0 (
        .i_clk           (clk),
        .i_nrst          (nrst),
        .i_fetch_en      (fetch_en),
        .i_flush         (flush),
        .i_redirect_pc   (redirect_pc),
        .i_stall         (stall),
        .i_we            (we),
        .i_waddr         (waddr),
        .i_wdata         (wdata),
        .i_progbuf_ena   (progbuf_ena),
        .i_progbuf_pc    (progbuf_pc),
        .i_progbuf_instr (progbuf_instr),
        .o_fetch         (dut_fetch),
        .o_fetching_pc   (fetching_pc)
    );

    bind fetch_ctrl fetch_checker u_checker (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_state     (r.state),
        .i_req       (o_mem_req),
        .i_mem_ready (i_mem_ready),
        .i_mem_resp  (i_mem_resp),
        .i_flush     (i_flush),
        .i_raw       (o_raw)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_fetch(input string name, input fetch_out_t got,
                                 input fetch_out_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic compare_pc(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                                    $time, name, got, exp));
        end
    endtask

    // Expected result built from the fetch rules
    function automatic fetch_out_t make_result(input addr_t pc, input logic from_pb,
                                               input logic [31:0] pb_word);
        fetch_out_t  res;
        fetch_word_u word;
        int unsigned idx;
        res = '0;
        idx = pc >> 2;
        res.valid   = 1'b1;
        res.pc      = pc;
        res.progbuf = from_pb;
        if (from_pb) begin
            word = pb_word;
        end else if (idx < MEM_WORDS) begin
            word = model_mem[idx];
        end else begin
            word           = '0;
            res.load_fault = 1'b1;
        end
        res.instr      = word;
        // Full 32-bit opcodes have both low bits set
        res.compressed = !(word.full.opcode[1] && word.full.opcode[0]);
        return res;
    endfunction

    // One cycle, sampled on the falling edge
    task automatic step();
        @(negedge clk);
        cycles++;
        if (cycles > cycle_limit) begin
            stop_on_error($sformatf("timeout: fetching stalled, %0d of %0d results in %0d cycles",
                                    results_seen, total_expected, cycles));
        end
        if (dut0.u_ctrl.u_checker.fail_count != 0) begin
            stop_on_error("a controller assertion failed");
        end
        if (dut_fetch.valid === 1'b1) begin
            if (exp_progbuf) begin
                compare_fetch("o_fetch", dut_fetch,
                              make_result(progbuf_pc, 1'b1, progbuf_instr));
                exp_progbuf = 1'b0;
            end else begin
                compare_fetch("o_fetch", dut_fetch, make_result(exp_pc, 1'b0, '0));
                exp_pc       = exp_pc + 16'd4;
                shadow_known = 1'b1;
            end
            results_seen++;
        end
    endtask

    task automatic drain();
        fetch_en = 1'b0;
        stall    = 1'b0;
        repeat (DRAIN_CYCLES) step();
        if (shadow_known) begin
            compare_pc("o_fetching_pc", fetching_pc, exp_pc - 16'd4);
        end
    endtask

    task automatic run_phase(input phase_t ph);
        int target;
        if (ph.flush) begin
            flush       = 1'b1;
            redirect_pc = ph.redirect_pc;
            // A result already past the controller may still appear
            step();
            flush        = 1'b0;
            exp_pc       = ph.redirect_pc;
            shadow_known = 1'b0;
        end
        if (ph.progbuf) begin
            drain();
            progbuf_pc    = addr_t'($urandom);
            progbuf_instr = $urandom;
            progbuf_ena   = 1'b1;
            exp_progbuf   = 1'b1;
            step();
            progbuf_ena = 1'b0;
        end
        fetch_en = ph.fetch_en;
        target   = results_seen + ph.count;
        while (results_seen < target) begin
            stall = (($urandom % 4) < ph.stall_quarters);
            step();
        end
        stall = 1'b0;
    endtask

    initial begin
        int i;
        void'($urandom(31));
        fetch_en      = 1'b0;
        flush         = 1'b0;
        stall         = 1'b0;
        we            = 1'b0;
        progbuf_ena   = 1'b0;
        redirect_pc   = '0;
        waddr         = '0;
        wdata         = '0;
        progbuf_pc    = '0;
        progbuf_instr = '0;
        exp_pc        = `FETCH_RESET_PC;
        exp_progbuf   = 1'b0;
        shadow_known  = 1'b0;
        results_seen  = 0;
        cycles        = 0;
        total_expected = 0;
        for (i = 0; i < NUM_PHASES; i++) begin
            total_expected += PHASES[i].count;
        end
        cycle_limit = total_expected * 8 + 50;

        // Outputs while reset is held
        @(negedge clk);
        compare_fetch("o_fetch", dut_fetch,
                      '{valid: 1'b0, pc: '1, instr: '0, compressed: 1'b0,
                        load_fault: 1'b0, progbuf: 1'b0});
        compare_pc("o_fetching_pc", fetching_pc, '1);
        wait (nrst === 1'b1);
        @(negedge clk);

        for (i = 0; i < MEM_WORDS; i++) begin
            we           = 1'b1;
            waddr        = addr_t'(i << 2);
            wdata        = $urandom;
            model_mem[i] = wdata;
            @(negedge clk);
        end
        we = 1'b0;

        for (i = 0; i < NUM_PHASES; i++) begin
            run_phase(PHASES[i]);
        end
        drain();

        if (results_seen >= total_expected && !exp_progbuf) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_on_error($sformatf("run ended with %0d of %0d results",
                                    results_seen, total_expected));
        end
    end

endmodule
